// ==== src/rv32f_cfg.svh ====
/*
 * build-wide sizes for the rv32f extension
 * register count, data width, canonical quiet nan
 */
`ifndef RV32F_CFG_SVH
`define RV32F_CFG_SVH

// f0..f31
`define RV32F_NREGS 32

// single precision only
`define RV32F_FLEN 32

// sign 0, exp all ones, quiet bit set
`define RV32F_CANON_NAN 32'h7FC0_0000

`endif

// ==== src/rv32f_isa_pkg.sv ====
/*
 * rv32f instruction encodings
 * plus one union giving r/i/s views of the same word
 */
`default_nettype none

package rv32f_isa_pkg;

  // major opcodes
  localparam logic [6:0] OPC_LOAD_FP  = 7'b000_0111;  // flw
  localparam logic [6:0] OPC_STORE_FP = 7'b010_0111;  // fsw
  localparam logic [6:0] OPC_OP_FP    = 7'b101_0011;  // op-fp

  // funct7, fmt field S (bits 26:25 = 00)
  localparam logic [6:0] F7_FADD  = 7'b000_0000;
  localparam logic [6:0] F7_FSUB  = 7'b000_0100;
  localparam logic [6:0] F7_FMUL  = 7'b000_1000;
  localparam logic [6:0] F7_FSGNJ = 7'b001_0000;

  // funct3 under F7_FSGNJ
  localparam logic [2:0] F3_SGNJ  = 3'b000;
  localparam logic [2:0] F3_SGNJN = 3'b001;
  localparam logic [2:0] F3_SGNJX = 3'b010;

  localparam logic [2:0] W_WIDTH = 3'b010;  // word width for flw/fsw

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;  // offset, used by host agu
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;    // data register for fsw
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } instr_word_u;

endpackage

`default_nettype wire

// ==== src/rv32f_ops_pkg.sv ====
/*
 * internal op codes passed down the pipe and fflags bit layout
 */
`default_nettype none

package rv32f_ops_pkg;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE,
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX
  } fp_op_e;

  // fflags positions, DZ (bit 3) never raised here
  localparam int FLAG_NX = 0;
  localparam int FLAG_UF = 1;
  localparam int FLAG_OF = 2;
  localparam int FLAG_NV = 4;

  // ops that land in an f register
  function automatic logic writes_fpr(fp_op_e op);
    return op inside {OP_LOAD, OP_ADD, OP_SUB, OP_MUL, OP_SGNJ, OP_SGNJN, OP_SGNJX};
  endfunction

endpackage

`default_nettype wire

// ==== src/rv32f_decode.sv ====
/*
 * decode stage, captures a started word and splits it into
 * an internal op, register indices and an illegal mark
 */
`default_nettype none

module rv32f_decode (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  logic [31:0]           instr,
  input  logic [31:0]           load_data,
  output logic                  dx_valid,
  output rv32f_ops_pkg::fp_op_e dx_op,
  output logic [4:0]            dx_rd,
  output logic [4:0]            dx_rs1,
  output logic [4:0]            dx_rs2,
  output logic [31:0]           dx_load_data,
  output logic                  dx_illegal
);
  rv32f_isa_pkg::instr_word_u iw;
  rv32f_ops_pkg::fp_op_e      op_c;
  logic                       illegal_c;
  logic [4:0]                 rd_c, rs1_c, rs2_c;

  assign iw = instr;

  always_comb begin
    op_c      = rv32f_ops_pkg::OP_NONE;
    illegal_c = 1'b0;
    // rd, rs1, rs2 sit at the same bits in every format
    rd_c      = iw.r_fmt.rd;
    rs1_c     = iw.r_fmt.rs1;
    rs2_c     = iw.r_fmt.rs2;
    case (iw.r_fmt.opcode)
      rv32f_isa_pkg::OPC_LOAD_FP: begin
        op_c      = rv32f_ops_pkg::OP_LOAD;  // rs1 is the base, only for the host
        illegal_c = (iw.i_fmt.funct3 != rv32f_isa_pkg::W_WIDTH);
      end
      rv32f_isa_pkg::OPC_STORE_FP: begin
        rd_c      = 5'd0;                     // nothing written
        op_c      = rv32f_ops_pkg::OP_STORE;  // store data from rs2
        illegal_c = (iw.s_fmt.funct3 != rv32f_isa_pkg::W_WIDTH);
      end
      rv32f_isa_pkg::OPC_OP_FP: begin
        case (iw.r_fmt.funct7)
          rv32f_isa_pkg::F7_FADD:  op_c = rv32f_ops_pkg::OP_ADD;
          rv32f_isa_pkg::F7_FSUB:  op_c = rv32f_ops_pkg::OP_SUB;
          rv32f_isa_pkg::F7_FMUL:  op_c = rv32f_ops_pkg::OP_MUL;
          rv32f_isa_pkg::F7_FSGNJ: begin
            case (iw.r_fmt.funct3)
              rv32f_isa_pkg::F3_SGNJ:  op_c = rv32f_ops_pkg::OP_SGNJ;
              rv32f_isa_pkg::F3_SGNJN: op_c = rv32f_ops_pkg::OP_SGNJN;
              rv32f_isa_pkg::F3_SGNJX: op_c = rv32f_ops_pkg::OP_SGNJX;
              default:                 illegal_c = 1'b1;
            endcase
          end
          default: illegal_c = 1'b1;  // div, sqrt, cvt, cmp ...
        endcase
      end
      default: illegal_c = 1'b1;
    endcase
    if (illegal_c) begin
      op_c = rv32f_ops_pkg::OP_NONE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dx_valid   <= 1'b0;
      dx_illegal <= 1'b0;
      dx_op      <= rv32f_ops_pkg::OP_NONE;
    end else begin
      dx_valid <= start;  // one stage per strobe, never stalls
      if (start) begin
        dx_illegal <= illegal_c;
        dx_op      <= op_c;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      dx_rd        <= rd_c;
      dx_rs1       <= rs1_c;
      dx_rs2       <= rs2_c;
      dx_load_data <= load_data;
    end
  end

  // host must present a clean word with the strobe
  a_instr_known: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> !$isunknown(instr));

endmodule

`default_nettype wire

// ==== src/rv32f_fp_regfile.sv ====
/*
 * floating-point register file
 * async read on two ports, one clocked write port
 */
`default_nettype none
`include "rv32f_cfg.svh"

module rv32f_fp_regfile (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);
  logic [`RV32F_FLEN-1:0] regs [`RV32F_NREGS];  // f0 is a normal register

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `RV32F_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // no internal bypass, execute forwards from result instead
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// ==== src/rv32f_execute.sv ====
/*
 * execute stage, forwarded operand select, fadd/fsub/fmul with rtz,
 * sign injection and load/store data, registered toward result
 */
`default_nettype none
`include "rv32f_cfg.svh"

module rv32f_execute (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dx_valid,
  input  rv32f_ops_pkg::fp_op_e dx_op,
  input  logic [4:0]            dx_rd,
  input  logic [4:0]            dx_rs1,
  input  logic [4:0]            dx_rs2,
  input  logic [31:0]           dx_load_data,
  input  logic                  dx_illegal,
  input  logic [31:0]           rdata1,
  input  logic [31:0]           rdata2,
  input  logic                  fwd_en,
  input  logic [4:0]            fwd_addr,
  input  logic [31:0]           fwd_data,
  output logic [4:0]            rd_idx1,
  output logic [4:0]            rd_idx2,
  output logic                  ex_valid,
  output logic                  ex_write,
  output logic                  ex_store,
  output logic                  ex_illegal,
  output logic [4:0]            ex_rd,
  output logic [31:0]           ex_value,
  output logic [4:0]            ex_flags
);
  logic [31:0] op_a, op_b;
  logic        a_zero, b_zero, a_spec, b_spec, is_mul, sb_eff;
  logic        swap, eff_sub, add_sign;   // add/sub path
  logic [7:0]  e_big, e_diff;
  logic [23:0] m_big, m_small;
  logic [53:0] y_wide;
  logic [26:0] y_al;
  logic [27:0] sum, sum_n;
  logic [4:0]  lead;
  logic [9:0]  add_exp;
  logic [47:0] prod;                      // mul path
  logic [9:0]  mul_exp;
  logic        r_sign, r_inx;             // shared pack
  logic [9:0]  r_exp;
  logic [22:0] r_frac;
  logic [31:0] arith_val, value_c;
  logic [4:0]  arith_flags, flags_c;

  assign rd_idx1 = dx_rs1;
  assign rd_idx2 = dx_rs2;
  // result is writing this cycle, regfile not updated yet
  assign op_a = (fwd_en && fwd_addr == dx_rs1) ? fwd_data : rdata1;
  assign op_b = (fwd_en && fwd_addr == dx_rs2) ? fwd_data : rdata2;

  assign a_zero = (op_a[30:23] == 8'h00);  // denormals flushed
  assign b_zero = (op_b[30:23] == 8'h00);
  assign a_spec = (op_a[30:23] == 8'hFF);  // inf or nan
  assign b_spec = (op_b[30:23] == 8'hFF);
  assign is_mul = (dx_op == rv32f_ops_pkg::OP_MUL);
  assign sb_eff = op_b[31] ^ (dx_op == rv32f_ops_pkg::OP_SUB);

  // align smaller magnitude, 2 guard bits + sticky below the mantissa
  always_comb begin
    swap     = (op_b[30:0] > op_a[30:0]);
    eff_sub  = op_a[31] ^ sb_eff;
    add_sign = swap ? sb_eff : op_a[31];
    e_big    = swap ? op_b[30:23] : op_a[30:23];
    e_diff   = swap ? op_b[30:23] - op_a[30:23] : op_a[30:23] - op_b[30:23];
    m_big    = swap ? {1'b1, op_b[22:0]} : {1'b1, op_a[22:0]};
    m_small  = swap ? {1'b1, op_a[22:0]} : {1'b1, op_b[22:0]};
    y_wide   = {m_small, 30'd0} >> e_diff;
    y_al     = y_wide[53:27];
    y_al[0]  = y_al[0] | (|y_wide[26:0]) | (e_diff > 8'd53);  // sticky
    sum      = eff_sub ? {1'b0, m_big, 3'b000} - {1'b0, y_al}
                       : {1'b0, m_big, 3'b000} + {1'b0, y_al};
    lead     = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (sum[i]) begin
        lead = 5'(i);  // topmost set bit wins
      end
    end
    sum_n    = sum << (5'd27 - lead);  // leading one to bit 27
    add_exp  = {2'b00, e_big} + {5'd0, lead} - 10'd26;
  end

  always_comb begin
    prod    = {1'b1, op_a[22:0]} * {1'b1, op_b[22:0]};  // 1.x * 1.x, in [1,4)
    mul_exp = {2'b00, op_a[30:23]} + {2'b00, op_b[30:23]} - 10'd127 + {9'd0, prod[47]};
  end

  // special cases, then overflow / underflow / truncate
  always_comb begin
    r_sign = is_mul ? op_a[31] ^ op_b[31] : add_sign;
    r_exp  = is_mul ? mul_exp : add_exp;
    if (is_mul) begin
      r_frac = prod[47] ? prod[46:24] : prod[45:23];
      r_inx  = prod[47] ? |prod[23:0] : |prod[22:0];
    end else begin
      r_frac = sum_n[26:4];
      r_inx  = |sum_n[3:0];
    end
    arith_flags = 5'd0;
    if (a_spec || b_spec) begin
      arith_val = `RV32F_CANON_NAN;
      arith_flags[rv32f_ops_pkg::FLAG_NV] = 1'b1;
    end else if (is_mul && (a_zero || b_zero)) begin
      arith_val = {r_sign, 31'd0};
    end else if (!is_mul && a_zero && b_zero) begin
      arith_val = {op_a[31] & sb_eff, 31'd0};  // -0 only from -0 + -0
    end else if (!is_mul && a_zero) begin
      arith_val = {sb_eff, op_b[30:0]};
    end else if (!is_mul && b_zero) begin
      arith_val = op_a;
    end else if (!is_mul && sum == 28'd0) begin
      arith_val = 32'd0;  // exact cancellation is +0 under rtz
    end else if (!r_exp[9] && r_exp > 10'd254) begin
      arith_val = {r_sign, 8'hFE, 23'h7F_FFFF};  // rtz clamps to max finite
      arith_flags[rv32f_ops_pkg::FLAG_OF] = 1'b1;
      arith_flags[rv32f_ops_pkg::FLAG_NX] = 1'b1;
    end else if (r_exp[9] || r_exp == 10'd0) begin
      arith_val = {r_sign, 31'd0};  // flush, no denormal outputs
      arith_flags[rv32f_ops_pkg::FLAG_UF] = 1'b1;
      arith_flags[rv32f_ops_pkg::FLAG_NX] = 1'b1;
    end else begin
      arith_val = {r_sign, r_exp[7:0], r_frac};
      arith_flags[rv32f_ops_pkg::FLAG_NX] = r_inx;
    end
  end

  always_comb begin
    flags_c = 5'd0;
    case (dx_op)
      rv32f_ops_pkg::OP_LOAD:  value_c = dx_load_data;
      rv32f_ops_pkg::OP_STORE: value_c = op_b;
      rv32f_ops_pkg::OP_SGNJ:  value_c = {op_b[31], op_a[30:0]};
      rv32f_ops_pkg::OP_SGNJN: value_c = {~op_b[31], op_a[30:0]};
      rv32f_ops_pkg::OP_SGNJX: value_c = {op_a[31] ^ op_b[31], op_a[30:0]};
      rv32f_ops_pkg::OP_ADD, rv32f_ops_pkg::OP_SUB, rv32f_ops_pkg::OP_MUL: begin
        value_c = arith_val;
        flags_c = arith_flags;
      end
      default: value_c = 32'd0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid   <= 1'b0;
      ex_write   <= 1'b0;
      ex_store   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= dx_valid;
      ex_illegal <= dx_valid & dx_illegal;
      ex_write   <= dx_valid & rv32f_ops_pkg::writes_fpr(dx_op);
      ex_store   <= dx_valid & (dx_op == rv32f_ops_pkg::OP_STORE);
    end
  end

  always_ff @(posedge CLK) begin
    ex_rd    <= dx_rd;
    ex_value <= value_c;
    ex_flags <= flags_c;
  end

  a_wr_st_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(ex_write && ex_store));

endmodule

`default_nettype wire

// ==== src/rv32f_result.sv ====
/*
 * result / writeback stage, regfile write, store data out,
 * sticky fflags and the done / illegal pulses
 */
`default_nettype none

module rv32f_result (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        ex_valid,
  input  logic        ex_write,
  input  logic        ex_store,
  input  logic        ex_illegal,
  input  logic [4:0]  ex_rd,
  input  logic [31:0] ex_value,
  input  logic [4:0]  ex_flags,
  output logic        wr_en,
  output logic [4:0]  wr_addr,
  output logic [31:0] wr_data,
  output logic        done,
  output logic        illegal,
  output logic        store_valid,
  output logic [31:0] store_data,
  output logic [4:0]  fflags
);
  // regfile takes it on the next edge, also the forwarding source
  assign wr_en   = ex_write;
  assign wr_addr = ex_rd;
  assign wr_data = ex_value;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done        <= 1'b0;
      illegal     <= 1'b0;
      store_valid <= 1'b0;
      fflags      <= 5'd0;
    end else begin
      done        <= ex_write | ex_store;  // every legal op writes or stores
      illegal     <= ex_illegal;
      store_valid <= ex_store;
      if (ex_valid) begin
        fflags <= fflags | ex_flags;  // sticky, no csr clear path
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ex_store) begin
      store_data <= ex_value;
    end
  end

  a_done_xor_ill: assert property (@(posedge CLK) disable iff (!nRST)
    !(done && illegal));

endmodule

`default_nettype wire

// ==== src/rv32f_ext_top.sv ====
/*
 * rv32f extension top, decode -> execute -> result
 * around the fp register file
 */
`default_nettype none
`include "rv32f_cfg.svh"

module rv32f_ext_top (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        start,
  input  logic [31:0] instr,
  input  logic [31:0] load_data,
  output logic        done,
  output logic        illegal,
  output logic        store_valid,
  output logic [31:0] store_data,
  output logic [4:0]  fflags
);
  // decode -> execute
  logic                   dx_valid, dx_illegal;
  rv32f_ops_pkg::fp_op_e  dx_op;
  logic [4:0]             dx_rd, dx_rs1, dx_rs2;
  logic [`RV32F_FLEN-1:0] dx_load_data;
  // execute <-> regfile
  logic [4:0]             rd_idx1, rd_idx2;
  logic [`RV32F_FLEN-1:0] rdata1, rdata2;
  // execute -> result
  logic                   ex_valid, ex_write, ex_store, ex_illegal;
  logic [4:0]             ex_rd, ex_flags;
  logic [`RV32F_FLEN-1:0] ex_value;
  // result -> regfile, and forward path
  logic                   wr_en;
  logic [4:0]             wr_addr;
  logic [`RV32F_FLEN-1:0] wr_data;

  rv32f_decode u_decode (.*);

  rv32f_execute u_execute (
    .fwd_en   (wr_en),
    .fwd_addr (wr_addr),
    .fwd_data (wr_data),
    .*
  );

  rv32f_fp_regfile u_regfile (
    .rs1 (rd_idx1),
    .rs2 (rd_idx2),
    .*
  );

  rv32f_result u_result (.*);

endmodule

`default_nettype wire

// ==== verification/rv32f_tb.sv ====
/*
 * testbench for the rv32f extension unit, exact rtz reference model
 * and concurrent checks on done, illegal, store and fflags outputs
 */
`default_nettype none

module rv32f_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int K_ADD = 0, K_SUB = 1, K_MUL = 2, K_SGNJ = 3, K_SGNJN = 4, K_SGNJX = 5;
  localparam int EV_DONE = 0, EV_STORE = 1, EV_ILL = 2;

  typedef struct {
    int          due;    // edge count where result stage registers it
    int          kind;
    logic [31:0] data;   // expected store data
    logic [4:0]  flags;  // sticky fflags once this one retires
  } ev_t;

  logic        CLK = 1'b0;
  logic        nRST, start;
  logic [31:0] instr, load_data, store_data;
  logic        done, illegal, store_valid;
  logic [4:0]  fflags;

  logic [31:0] mregs [32];      // model of f0..f31
  logic [4:0]  mflags = 5'd0;
  logic [31:0] rng = 32'd78597;
  ev_t         q[$];            // in program order, one per start
  int          cyc = 0;
  int          err_value = 0;
  int          err_other = 0;
  logic        exp_done = 1'b0, exp_ill = 1'b0, exp_st = 1'b0;
  logic [31:0] exp_sdata = 32'd0;
  logic [4:0]  exp_fflags = 5'd0;

  rv32f_ext_top DUT (.*);

  always #5 CLK = ~CLK;

  // expected outputs follow the dut by the same edge
  always @(posedge CLK) begin
    cyc      <= cyc + 1;
    exp_done <= 1'b0;
    exp_ill  <= 1'b0;
    exp_st   <= 1'b0;
    if (q.size() > 0 && q[0].due == cyc) begin
      exp_done   <= (q[0].kind != EV_ILL);
      exp_ill    <= (q[0].kind == EV_ILL);
      exp_st     <= (q[0].kind == EV_STORE);
      exp_sdata  <= q[0].data;
      exp_fflags <= q[0].flags;
      void'(q.pop_front());
    end
  end

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] gotv);
    $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expv, gotv);
    err_value++;
  endtask

  a_done: assert property (@(posedge CLK) disable iff (!nRST) done == exp_done)
    else report_value("done", 32'($sampled(exp_done)), 32'($sampled(done)));
  a_ill: assert property (@(posedge CLK) disable iff (!nRST) illegal == exp_ill)
    else report_value("illegal", 32'($sampled(exp_ill)), 32'($sampled(illegal)));
  a_st: assert property (@(posedge CLK) disable iff (!nRST) store_valid == exp_st)
    else report_value("store_valid", 32'($sampled(exp_st)), 32'($sampled(store_valid)));
  a_sdata: assert property (@(posedge CLK) disable iff (!nRST)
    exp_st |-> store_data == exp_sdata)
    else report_value("store_data", $sampled(exp_sdata), $sampled(store_data));
  a_flags: assert property (@(posedge CLK) disable iff (!nRST) fflags == exp_fflags)
    else report_value("fflags", 32'($sampled(exp_fflags)), 32'($sampled(fflags)));

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // normal value, exponent kept in 120..135
  function automatic logic [31:0] rand_normal();
    logic [31:0] r;
    r = xorshift32();
    return {r[31], 8'd120 + {4'd0, r[26:23]}, r[22:0]};
  endfunction

  // {fflags, value}, exact magnitude then truncation toward zero
  function automatic logic [36:0] rtz_model(input int kind, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [319:0] ma, mb, mag;
    logic         sa, sb, rs, nx;
    logic [22:0]  frac;
    int           ea, eb, emin, e0, p, be;
    sa = a[31];
    sb = b[31] ^ (kind == K_SUB);  // sub is add of negated b
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    if (kind == K_SGNJ) return {5'd0, b[31], a[30:0]};
    if (kind == K_SGNJN) return {5'd0, ~b[31], a[30:0]};
    if (kind == K_SGNJX) return {5'd0, a[31] ^ b[31], a[30:0]};
    if (ea == 255 || eb == 255) return {5'b10000, 32'h7FC0_0000};  // nv, canonical nan
    if (kind == K_MUL) begin
      rs = a[31] ^ b[31];
      if (ea == 0 || eb == 0) return {5'd0, rs, 31'd0};  // denormal is zero
      mag = {1'b1, a[22:0]} * {1'b1, b[22:0]};
      e0  = ea + eb - 300;  // value is mag * 2^e0
    end else begin
      if (ea == 0 && eb == 0) return {5'd0, sa & sb, 31'd0};
      if (ea == 0) return {5'd0, sb, b[30:0]};
      if (eb == 0) return {5'd0, a};
      emin = (ea < eb) ? ea : eb;
      ma   = 320'({1'b1, a[22:0]}) << (ea - emin);
      mb   = 320'({1'b1, b[22:0]}) << (eb - emin);
      e0   = emin - 150;
      if (sa == sb) begin
        mag = ma + mb;
        rs  = sa;
      end else if (ma >= mb) begin
        mag = ma - mb;
        rs  = sa;
      end else begin
        mag = mb - ma;
        rs  = sb;
      end
      if (mag == 320'd0) return 37'd0;  // exact cancellation gives +0
    end
    p = 0;
    for (int i = 0; i < 320; i++) begin
      if (mag[i]) p = i;
    end
    be = e0 + p + 127;
    if (be >= 255) return {5'b00101, rs, 8'hFE, 23'h7F_FFFF};  // of + nx, max finite
    if (be <= 0) return {5'b00011, rs, 31'd0};                 // uf + nx, flushed
    if (p >= 23) begin
      frac = 23'(mag >> (p - 23));
      nx   = (mag & ((320'd1 << (p - 23)) - 320'd1)) != 320'd0;
    end else begin
      frac = 23'(mag << (23 - p));  // small difference, nothing dropped
      nx   = 1'b0;
    end
    return {4'd0, nx, rs, 8'(be), frac};
  endfunction

  // one start strobe, expectation due two edges after capture
  task automatic issue(input logic [31:0] word, input logic [31:0] ldata, input int kind,
                       input logic [31:0] sdata);
    ev_t e;
    @(posedge CLK);
    #1;
    start     = 1'b1;
    instr     = word;
    load_data = ldata;
    e.due     = cyc + 2;
    e.kind    = kind;
    e.data    = sdata;
    e.flags   = mflags;
    q.push_back(e);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] d);
    mregs[rd] = d;
    issue({12'h010, 5'd2, 3'b010, rd, 7'h07}, d, EV_DONE, 32'd0);  // flw
  endtask

  task automatic store_reg(input logic [4:0] rs2);
    issue({7'h00, rs2, 5'd2, 3'b010, 5'h04, 7'h27}, 32'd0, EV_STORE, mregs[rs2]);  // fsw
  endtask

  task automatic exec_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2);
    logic [36:0] r;
    logic [6:0]  f7;
    logic [2:0]  f3;
    r  = rtz_model(kind, mregs[rs1], mregs[rs2]);
    f7 = (kind == K_ADD) ? 7'h00 : (kind == K_SUB) ? 7'h04 : (kind == K_MUL) ? 7'h08 : 7'h10;
    f3 = (kind >= K_SGNJ) ? 3'(kind - K_SGNJ) : 3'b001;  // rm=rtz, unit ignores it
    mregs[rd] = r[31:0];
    mflags    = mflags | r[36:32];
    issue({f7, rs2, rs1, f3, rd, 7'h53}, 32'd0, EV_DONE, 32'd0);
  endtask

  // f1, f2 loaded, f3 = f1 op f2, then stored
  task automatic binop_case(input int kind, input logic [31:0] a, input logic [31:0] b);
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    exec_op(kind, 5'd3, 5'd1, 5'd2);
    store_reg(5'd3);
  endtask

  task automatic drain_events();
    int n;
    @(posedge CLK);
    #1;
    start = 1'b0;
    n = 0;
    while (q.size() > 0 && n < 10) begin
      @(posedge CLK);
      n++;
    end
    if (q.size() > 0) begin
      $display("timeout: %0d expected results never came due", q.size());
      err_other++;
      q.delete();
    end
    repeat (2) @(posedge CLK);  // last event is checked one edge after due
  endtask

  initial begin
    logic [31:0] d;
    nRST      = 1'b0;
    start     = 1'b0;
    instr     = 32'd0;
    load_data = 32'd0;
    for (int i = 0; i < 32; i++) mregs[i] = 32'd0;
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    for (int i = 0; i < 32; i++) begin  // every reg loaded and read back
      d = rand_normal();
      load_reg(5'(i), d);
      store_reg(5'(i));
    end
    drain_events();
    for (int i = 0; i < 9; i++) binop_case(K_SGNJ + i % 3, rand_normal(), rand_normal());
    drain_events();
    binop_case(K_ADD, 32'h3F80_0000, 32'h3F80_0000);  // exact sums, nx still clear
    binop_case(K_SUB, 32'h4040_0000, 32'h3F80_0000);
    d = rand_normal();
    binop_case(K_SUB, d, d);
    for (int i = 0; i < 24; i++) binop_case(K_ADD + i % 2, rand_normal(), rand_normal());
    drain_events();
    binop_case(K_MUL, 32'h7F80_0000, 32'h3F80_0000);  // inf operand
    binop_case(K_MUL, 32'h7FC0_0001, 32'h4000_0000);  // nan operand
    binop_case(K_MUL, 32'h0000_0000, 32'hC000_0000);  // -0, no flags
    binop_case(K_MUL, 32'h8080_0000, 32'h3F00_0000);  // underflow to -0
    binop_case(K_MUL, 32'h7F00_0000, 32'hC000_0000);  // overflow to -max
    for (int i = 0; i < 12; i++) binop_case(K_MUL, rand_normal(), rand_normal());
    drain_events();
    exec_op(K_ADD, 5'd5, 5'd1, 5'd2);  // chain, each needs the one before
    exec_op(K_MUL, 5'd6, 5'd5, 5'd1);
    exec_op(K_SGNJX, 5'd7, 5'd6, 5'd5);
    exec_op(K_SUB, 5'd8, 5'd7, 5'd6);
    exec_op(K_ADD, 5'd8, 5'd8, 5'd8);
    store_reg(5'd8);
    store_reg(5'd7);
    drain_events();
    issue({7'h0C, 5'd2, 5'd1, 3'b000, 5'd3, 7'h53}, 32'd0, EV_ILL, 32'd0);  // fdiv
    issue({7'h2C, 5'd0, 5'd1, 3'b000, 5'd4, 7'h53}, 32'd0, EV_ILL, 32'd0);  // fsqrt
    issue({7'h10, 5'd2, 5'd1, 3'b011, 5'd5, 7'h53}, 32'd0, EV_ILL, 32'd0);  // bad sgnj f3
    issue({12'h000, 5'd1, 3'b011, 5'd6, 7'h07}, 32'hDEAD_BEEF, EV_ILL, 32'd0);  // fld
    issue({7'h00, 5'd2, 5'd1, 3'b000, 5'd7, 7'h33}, 32'd0, EV_ILL, 32'd0);  // int add
    issue({7'h01, 5'd2, 5'd1, 3'b000, 5'd8, 7'h53}, 32'd0, EV_ILL, 32'd0);  // fadd.d
    for (int i = 3; i <= 8; i++) store_reg(5'(i));  // targets untouched
    drain_events();
    $display("errors: value %0d, other %0d", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/rv32f_isa_pkg.sv
src/rv32f_ops_pkg.sv
src/rv32f_decode.sv
src/rv32f_fp_regfile.sv
src/rv32f_execute.sv
src/rv32f_result.sv
src/rv32f_ext_top.sv
verification/rv32f_tb.sv
